//--- flist.f
+incdir+src
src/bus_pkg.sv
src/clint_pkg.sv
src/addr_decode.sv
src/port_router.sv
src/bram_mem.sv
src/clint_timer.sv
src/soc_bus.sv
test/soc_bus_props.sv
test/soc_bus_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass message shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module soc_bus_tb \
  && ./obj_dir/Vsoc_bus_tb | tee /dev/stderr | grep "Test passed" > /dev/null \
  || exit 1

//--- test/soc_bus_tb.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module soc_bus_tb;

  localparam int          RAND_OPS      = 40;
  localparam int          MTIP_POLLS    = 80;              // mtime reads before giving up.
  localparam int          ACCESS_BUDGET = 46 + RAND_OPS + MTIP_POLLS;  // Accesses over all tests.
  localparam int          WATCHDOG_CYC  = ACCESS_BUDGET * 50 + 500;
  localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;

  logic        clk;
  logic        rst;
  logic        imem_valid;
  logic [31:0] imem_addr;
  logic [31:0] imem_wdata;
  logic [3:0]  imem_wstrb;
  logic [31:0] imem_rdata;
  logic        imem_ready;
  logic        dmem_valid;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_rdata;
  logic        dmem_ready;
  logic        msip;
  logic        mtip;

  logic [31:0] lfsr_state = 32'hb619_b27e;
  logic [31:0] model [16];  // Reference copy of the RAM words in use.
  time         d_ready_at;
  time         i_ready_at;
  int          n_checks = 0;
  int          n_errors = 0;

  soc_bus soc_bus_inst (
    .clk          (clk),
    .rst          (rst),
    .imem_valid_i (imem_valid),
    .imem_addr_i  (imem_addr),
    .imem_wdata_i (imem_wdata),
    .imem_wstrb_i (imem_wstrb),
    .imem_rdata_o (imem_rdata),
    .imem_ready_o (imem_ready),
    .dmem_valid_i (dmem_valid),
    .dmem_addr_i  (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .dmem_wstrb_i (dmem_wstrb),
    .dmem_rdata_o (dmem_rdata),
    .dmem_ready_o (dmem_ready),
    .msip_o       (msip),
    .mtip_o       (mtip)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers and compare tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Galois LFSR, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (fb) lfsr_state = lfsr_state ^ LFSR_TAPS;
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] ram_addr(input int idx);
    return `SOC_BRAM_BASE + 32'h200 + 32'(idx << 2);
  endfunction

  function automatic logic [31:0] clint_addr(input clint_pkg::clint_reg_e r);
    return `SOC_CLINT_BASE + 32'(r);
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_target(input string name, input bus_pkg::target_e got,
                              input bus_pkg::target_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic fail_plain(input string what);
    n_errors++;
    $display("Error: %s at %0t", what, $time);
  endtask

  // Called 1 ns after an edge; returns 1 ns after the edge that ends the ready cycle.
  task automatic do_access_d(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, input bus_pkg::target_e tgt,
                             output logic [31:0] rdata);
    dmem_addr  = addr;
    dmem_wdata = wdata;
    dmem_wstrb = strb;
    dmem_valid = 1'b1;
    #1;
    check_target("dmem_target", soc_bus_inst.port_router_inst.dmem_target, tgt);
    do begin
      @(posedge clk);
      #1;
    end while (!dmem_ready);
    rdata      = dmem_rdata;
    d_ready_at = $time;
    @(posedge clk);
    #1;
    dmem_valid = 1'b0;
  endtask

  task automatic do_access_i(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, output logic [31:0] rdata);
    imem_addr  = addr;
    imem_wdata = wdata;
    imem_wstrb = strb;
    imem_valid = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!imem_ready);
    rdata      = imem_rdata;
    i_ready_at = $time;
    @(posedge clk);
    #1;
    imem_valid = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_ram_random();
    logic [31:0] rd;
    logic [31:0] wd;
    logic [3:0]  strb;
    int          idx;
    for (int i = 0; i < 16; i++) begin
      wd = rand_bits(32);
      do_access_d(ram_addr(i), wd, 4'hf, bus_pkg::TGT_BRAM, rd);
      model[i] = wd;
    end
    for (int n = 0; n < RAND_OPS; n++) begin
      idx  = int'(rand_bits(4));
      strb = 4'(rand_bits(4));  // Zero strobe makes it a read.
      wd   = rand_bits(32);
      do_access_d(ram_addr(idx), wd, strb, bus_pkg::TGT_BRAM, rd);
      if (strb == 4'h0) begin
        check_word("dmem_rdata_o", rd, model[idx]);
      end
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) model[idx][8*b +: 8] = wd[8*b +: 8];
      end
    end
  endtask

  task automatic test_instr_reads();
    logic [31:0] rd;
    for (int i = 0; i < 16; i++) begin
      do_access_i(ram_addr(i), 32'h0, 4'h0, rd);
      check_word("imem_rdata_o", rd, model[i]);
    end
  endtask

  task automatic test_contested_ram();
    logic [31:0] rd_d;
    logic [31:0] rd_i;
    logic [31:0] wd;
    wd = rand_bits(32);
    fork
      do_access_d(ram_addr(3), wd, 4'hf, bus_pkg::TGT_BRAM, rd_d);
      do_access_i(ram_addr(5), 32'h0, 4'h0, rd_i);
    join
    model[3] = wd;
    check_word("imem_rdata_o", rd_i, model[5]);
    if (d_ready_at > i_ready_at) fail_plain("data port answered after instruction port");
    do_access_d(ram_addr(3), 32'h0, 4'h0, bus_pkg::TGT_BRAM, rd_d);
    check_word("dmem_rdata_o", rd_d, model[3]);
  endtask

  task automatic test_split_targets();
    logic [31:0] rd_d;
    logic [31:0] rd_i;
    fork
      do_access_i(ram_addr(7), 32'h0, 4'h0, rd_i);
      do_access_d(clint_addr(clint_pkg::REG_CMP_HI), 32'h0, 4'h0, bus_pkg::TGT_CLINT, rd_d);
    join
    check_word("imem_rdata_o", rd_i, model[7]);
    check_word("dmem_rdata_o", rd_d, 32'hffff_ffff);  // mtimecmp resets to all ones.
  endtask

  task automatic test_msip_cmp();
    logic [31:0] rd;
    do_access_d(clint_addr(clint_pkg::REG_MSIP), 32'h1, 4'hf, bus_pkg::TGT_CLINT, rd);
    check_bit("msip_o", msip, 1'b1);
    do_access_d(clint_addr(clint_pkg::REG_MSIP), 32'h0, 4'h0, bus_pkg::TGT_CLINT, rd);
    check_word("dmem_rdata_o", rd, 32'h1);
    do_access_d(clint_addr(clint_pkg::REG_MSIP), 32'h0, 4'hf, bus_pkg::TGT_CLINT, rd);
    check_bit("msip_o", msip, 1'b0);
    do_access_d(clint_addr(clint_pkg::REG_CMP_HI), 32'h0, 4'hf, bus_pkg::TGT_CLINT, rd);
    do_access_d(clint_addr(clint_pkg::REG_CMP_LO), 32'h0010_0000, 4'hf,
                bus_pkg::TGT_CLINT, rd);
    do_access_d(clint_addr(clint_pkg::REG_CMP_LO), 32'h0, 4'h0, bus_pkg::TGT_CLINT, rd);
    check_word("dmem_rdata_o", rd, 32'h0010_0000);
    do_access_d(clint_addr(clint_pkg::REG_CMP_HI), 32'h0, 4'h0, bus_pkg::TGT_CLINT, rd);
    check_word("dmem_rdata_o", rd, 32'h0);
    check_bit("mtip_o", mtip, 1'b0);
  endtask

  task automatic test_mtip();
    logic [31:0] rd;
    logic [31:0] prev;
    int          n;
    do_access_d(clint_addr(clint_pkg::REG_TIME_HI), 32'h0, 4'hf, bus_pkg::TGT_CLINT, rd);
    do_access_d(clint_addr(clint_pkg::REG_TIME_LO), 32'h000f_fff0, 4'hf,
                bus_pkg::TGT_CLINT, rd);
    check_bit("mtip_o", mtip, 1'b0);  // Still 16 ticks short.
    prev = 32'h000f_fff0;
    n    = 0;
    while (!mtip && n < MTIP_POLLS) begin
      do_access_d(clint_addr(clint_pkg::REG_TIME_LO), 32'h0, 4'h0, bus_pkg::TGT_CLINT, rd);
      if (rd < prev) fail_plain("mtime read went backwards");
      prev = rd;
      n++;
    end
    if (!mtip) fail_plain("mtip_o did not rise after mtime passed mtimecmp");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequence and watchdog.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst        = 1'b0;
    imem_valid = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    imem_wstrb = '0;
    dmem_valid = 1'b0;
    dmem_addr  = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;
    test_ram_random();
    test_instr_reads();
    test_contested_ram();
    test_split_targets();
    test_msip_cmp();
    test_mtip();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Error: run did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Test failed");
    $finish;
  end

endmodule

//--- test/soc_bus_props.sv
`timescale 1ns/1ps

module soc_bus_props (
  input logic            clk,
  input logic            rst,
  input logic            imem_valid_i,
  input logic            dmem_valid_i,
  input logic            imem_ready_i,
  input logic            dmem_ready_i,
  input logic            bram_valid_i,
  input logic            clint_valid_i,
  input bus_pkg::owner_e bram_owner_i,
  input bus_pkg::owner_e clint_owner_i
);

  // Ready is a one-cycle pulse.
  imem_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    imem_ready_i |=> !imem_ready_i) else $error("imem ready held longer than one cycle");
  dmem_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    dmem_ready_i |=> !dmem_ready_i) else $error("dmem ready held longer than one cycle");

  imem_ready_valid: assert property (@(posedge clk) disable iff (!rst)
    imem_ready_i |-> imem_valid_i) else $error("imem ready without a request");
  dmem_ready_valid: assert property (@(posedge clk) disable iff (!rst)
    dmem_ready_i |-> dmem_valid_i) else $error("dmem ready without a request");

  // A grant lasts one cycle and leaves the target owned.
  bram_grant_once: assert property (@(posedge clk) disable iff (!rst)
    bram_valid_i |=> bram_owner_i != bus_pkg::OWN_IDLE && !bram_valid_i)
    else $error("bram valid not followed by an owned target");
  clint_grant_once: assert property (@(posedge clk) disable iff (!rst)
    clint_valid_i |=> clint_owner_i != bus_pkg::OWN_IDLE && !clint_valid_i)
    else $error("clint valid not followed by an owned target");

endmodule

bind port_router soc_bus_props soc_bus_props_inst (
  .clk           (clk),
  .rst           (rst),
  .imem_valid_i  (imem_valid_i),
  .dmem_valid_i  (dmem_valid_i),
  .imem_ready_i  (imem_ready_o),
  .dmem_ready_i  (dmem_ready_o),
  .bram_valid_i  (bram_valid_o),
  .clint_valid_i (clint_valid_o),
  .bram_owner_i  (bram_owner_q),
  .clint_owner_i (clint_owner_q)
);

//--- src/soc_bus.sv
`timescale 1ns/1ps

module soc_bus (
  input  logic        clk,
  input  logic        rst,

  input  logic        imem_valid_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,

  input  logic        dmem_valid_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,

  output logic        msip_o,
  output logic        mtip_o
);

  logic        bram_valid;
  logic [31:0] bram_offset;
  logic [31:0] bram_wdata;
  logic [3:0]  bram_wstrb;
  logic [31:0] bram_rdata;
  logic        bram_ready;

  logic        clint_valid;
  logic [31:0] clint_offset;
  logic [31:0] clint_wdata;
  logic [3:0]  clint_wstrb;
  logic [31:0] clint_rdata;
  logic        clint_ready;

  port_router port_router_inst (
    .clk            (clk),
    .rst            (rst),
    .imem_valid_i   (imem_valid_i),
    .imem_addr_i    (imem_addr_i),
    .imem_wdata_i   (imem_wdata_i),
    .imem_wstrb_i   (imem_wstrb_i),
    .imem_rdata_o   (imem_rdata_o),
    .imem_ready_o   (imem_ready_o),
    .dmem_valid_i   (dmem_valid_i),
    .dmem_addr_i    (dmem_addr_i),
    .dmem_wdata_i   (dmem_wdata_i),
    .dmem_wstrb_i   (dmem_wstrb_i),
    .dmem_rdata_o   (dmem_rdata_o),
    .dmem_ready_o   (dmem_ready_o),
    .bram_valid_o   (bram_valid),
    .bram_offset_o  (bram_offset),
    .bram_wdata_o   (bram_wdata),
    .bram_wstrb_o   (bram_wstrb),
    .bram_rdata_i   (bram_rdata),
    .bram_ready_i   (bram_ready),
    .clint_valid_o  (clint_valid),
    .clint_offset_o (clint_offset),
    .clint_wdata_o  (clint_wdata),
    .clint_wstrb_o  (clint_wstrb),
    .clint_rdata_i  (clint_rdata),
    .clint_ready_i  (clint_ready)
  );

  bram_mem bram_mem_inst (
    .clk      (clk),
    .rst      (rst),
    .valid_i  (bram_valid),
    .offset_i (bram_offset),
    .wdata_i  (bram_wdata),
    .wstrb_i  (bram_wstrb),
    .rdata_o  (bram_rdata),
    .ready_o  (bram_ready)
  );

  clint_timer clint_timer_inst (
    .clk      (clk),
    .rst      (rst),
    .valid_i  (clint_valid),
    .offset_i (clint_offset),
    .wdata_i  (clint_wdata),
    .wstrb_i  (clint_wstrb),
    .rdata_o  (clint_rdata),
    .ready_o  (clint_ready),
    .msip_o   (msip_o),
    .mtip_o   (mtip_o)
  );

endmodule

//--- src/clint_timer.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module clint_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic [31:0] offset_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic [31:0] rdata_o,
  output logic        ready_o,
  output logic        msip_o,
  output logic        mtip_o
);

  localparam int DIV_W = $clog2(`SOC_RTC_DIV + 1);

  clint_pkg::clint_reg_e reg_sel;
  logic                  wr;
  logic                  tick;
  logic [DIV_W-1:0]      div_q;
  logic [63:0]           mtime_q;
  logic [63:0]           mtimecmp_q;

  always_comb begin
    reg_sel = clint_pkg::REG_NONE;
    if (offset_i[31:16] == 16'h0000) begin
      case (offset_i[15:0])
        clint_pkg::REG_MSIP:    reg_sel = clint_pkg::REG_MSIP;
        clint_pkg::REG_CMP_LO:  reg_sel = clint_pkg::REG_CMP_LO;
        clint_pkg::REG_CMP_HI:  reg_sel = clint_pkg::REG_CMP_HI;
        clint_pkg::REG_TIME_LO: reg_sel = clint_pkg::REG_TIME_LO;
        clint_pkg::REG_TIME_HI: reg_sel = clint_pkg::REG_TIME_HI;
        default:                reg_sel = clint_pkg::REG_NONE;
      endcase
    end
  end

  assign wr   = valid_i && (wstrb_i != 4'b0000);  // Whole-word writes.
  assign tick = (div_q == DIV_W'(`SOC_RTC_DIV - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registers and real-time counter.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst) begin
      div_q      <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_o     <= 1'b0;
      mtip_o     <= 1'b0;
      ready_o    <= 1'b0;
    end else begin
      div_q   <= tick ? '0 : div_q + 1'b1;
      ready_o <= valid_i;
      mtip_o  <= (mtime_q >= mtimecmp_q);
      // A write to mtime takes precedence over the tick.
      if (wr && reg_sel == clint_pkg::REG_TIME_LO) begin
        mtime_q <= {mtime_q[63:32], wdata_i};
      end else if (wr && reg_sel == clint_pkg::REG_TIME_HI) begin
        mtime_q <= {wdata_i, mtime_q[31:0]};
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && reg_sel == clint_pkg::REG_MSIP) msip_o <= wdata_i[0];
      if (wr && reg_sel == clint_pkg::REG_CMP_LO) mtimecmp_q[31:0] <= wdata_i;
      if (wr && reg_sel == clint_pkg::REG_CMP_HI) mtimecmp_q[63:32] <= wdata_i;
    end
  end

  // Read data.
  always_ff @(posedge clk) begin
    if (valid_i) begin
      case (reg_sel)
        clint_pkg::REG_MSIP:    rdata_o <= {31'b0, msip_o};
        clint_pkg::REG_CMP_LO:  rdata_o <= mtimecmp_q[31:0];
        clint_pkg::REG_CMP_HI:  rdata_o <= mtimecmp_q[63:32];
        clint_pkg::REG_TIME_LO: rdata_o <= mtime_q[31:0];
        clint_pkg::REG_TIME_HI: rdata_o <= mtime_q[63:32];
        default:                rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- src/bram_mem.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module bram_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid_i,
  input  logic [31:0] offset_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  wstrb_i,
  output logic [31:0] rdata_o,
  output logic        ready_o
);

  localparam int IDX_W = $clog2(`SOC_BRAM_WORDS);

  logic [31:0]      mem [`SOC_BRAM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = offset_i[IDX_W+1:2];  // Word index.

  // Array and read port.
  always_ff @(posedge clk) begin
    if (valid_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[idx];  // Old word, only meaningful on reads.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= valid_i;
    end
  end

endmodule

//--- src/port_router.sv
`timescale 1ns/1ps

module port_router (
  input  logic        clk,
  input  logic        rst,

  input  logic        imem_valid_i,
  input  logic [31:0] imem_addr_i,
  input  logic [31:0] imem_wdata_i,
  input  logic [3:0]  imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic        imem_ready_o,

  input  logic        dmem_valid_i,
  input  logic [31:0] dmem_addr_i,
  input  logic [31:0] dmem_wdata_i,
  input  logic [3:0]  dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic        dmem_ready_o,

  output logic        bram_valid_o,
  output logic [31:0] bram_offset_o,
  output logic [31:0] bram_wdata_o,
  output logic [3:0]  bram_wstrb_o,
  input  logic [31:0] bram_rdata_i,
  input  logic        bram_ready_i,

  output logic        clint_valid_o,
  output logic [31:0] clint_offset_o,
  output logic [31:0] clint_wdata_o,
  output logic [3:0]  clint_wstrb_o,
  input  logic [31:0] clint_rdata_i,
  input  logic        clint_ready_i
);

  bus_pkg::target_e imem_target;
  bus_pkg::target_e dmem_target;
  logic [31:0]      imem_offset;
  logic [31:0]      dmem_offset;

  bus_pkg::owner_e  bram_owner_q;
  bus_pkg::owner_e  clint_owner_q;
  bus_pkg::owner_e  bram_grant;
  bus_pkg::owner_e  clint_grant;

  logic             imem_busy;
  logic             dmem_busy;

  // Data port wins a tie on an idle target.
  function automatic bus_pkg::owner_e pick_owner(
    input bus_pkg::target_e tgt,
    input bus_pkg::owner_e  owner,
    input bus_pkg::target_e i_tgt,
    input bus_pkg::target_e d_tgt,
    input logic             i_busy,
    input logic             d_busy
  );
    bus_pkg::owner_e win;
    win = bus_pkg::OWN_IDLE;
    if (owner == bus_pkg::OWN_IDLE) begin
      if (d_tgt == tgt && !d_busy) begin
        win = bus_pkg::OWN_DATA;
      end else if (i_tgt == tgt && !i_busy) begin
        win = bus_pkg::OWN_INSTR;
      end
    end
    return win;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode and grant.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  addr_decode imem_decode_inst (
    .addr_i   (imem_addr_i),
    .valid_i  (imem_valid_i),
    .target_o (imem_target),
    .offset_o (imem_offset)
  );

  addr_decode dmem_decode_inst (
    .addr_i   (dmem_addr_i),
    .valid_i  (dmem_valid_i),
    .target_o (dmem_target),
    .offset_o (dmem_offset)
  );

  // Owner stays set through the ready cycle, so this also blocks a regrant.
  assign imem_busy = (bram_owner_q == bus_pkg::OWN_INSTR) ||
                     (clint_owner_q == bus_pkg::OWN_INSTR);
  assign dmem_busy = (bram_owner_q == bus_pkg::OWN_DATA) ||
                     (clint_owner_q == bus_pkg::OWN_DATA);

  assign bram_grant  = pick_owner(bus_pkg::TGT_BRAM, bram_owner_q,
                                  imem_target, dmem_target, imem_busy, dmem_busy);
  assign clint_grant = pick_owner(bus_pkg::TGT_CLINT, clint_owner_q,
                                  imem_target, dmem_target, imem_busy, dmem_busy);

  always_ff @(posedge clk) begin
    if (!rst) begin
      bram_owner_q  <= bus_pkg::OWN_IDLE;
      clint_owner_q <= bus_pkg::OWN_IDLE;
    end else begin
      if (bram_ready_i) begin
        bram_owner_q <= bus_pkg::OWN_IDLE;
      end else if (bram_grant != bus_pkg::OWN_IDLE) begin
        bram_owner_q <= bram_grant;
      end
      if (clint_ready_i) begin
        clint_owner_q <= bus_pkg::OWN_IDLE;
      end else if (clint_grant != bus_pkg::OWN_IDLE) begin
        clint_owner_q <= clint_grant;
      end
    end
  end

  // Request steering, valid only in the grant cycle.
  assign bram_valid_o   = (bram_grant != bus_pkg::OWN_IDLE);
  assign bram_offset_o  = (bram_grant == bus_pkg::OWN_DATA) ? dmem_offset : imem_offset;
  assign bram_wdata_o   = (bram_grant == bus_pkg::OWN_DATA) ? dmem_wdata_i : imem_wdata_i;
  assign bram_wstrb_o   = (bram_grant == bus_pkg::OWN_DATA) ? dmem_wstrb_i : imem_wstrb_i;

  assign clint_valid_o  = (clint_grant != bus_pkg::OWN_IDLE);
  assign clint_offset_o = (clint_grant == bus_pkg::OWN_DATA) ? dmem_offset : imem_offset;
  assign clint_wdata_o  = (clint_grant == bus_pkg::OWN_DATA) ? dmem_wdata_i : imem_wdata_i;
  assign clint_wstrb_o  = (clint_grant == bus_pkg::OWN_DATA) ? dmem_wstrb_i : imem_wstrb_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response return by owner.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    imem_ready_o = 1'b0;
    imem_rdata_o = '0;
    dmem_ready_o = 1'b0;
    dmem_rdata_o = '0;
    if (bram_ready_i && bram_owner_q == bus_pkg::OWN_DATA) begin
      dmem_ready_o = 1'b1;
      dmem_rdata_o = bram_rdata_i;
    end else if (bram_ready_i && bram_owner_q == bus_pkg::OWN_INSTR) begin
      imem_ready_o = 1'b1;
      imem_rdata_o = bram_rdata_i;
    end
    if (clint_ready_i && clint_owner_q == bus_pkg::OWN_DATA) begin
      dmem_ready_o = 1'b1;
      dmem_rdata_o = clint_rdata_i;
    end else if (clint_ready_i && clint_owner_q == bus_pkg::OWN_INSTR) begin
      imem_ready_o = 1'b1;
      imem_rdata_o = clint_rdata_i;
    end
  end

endmodule

//--- src/addr_decode.sv
`timescale 1ns/1ps

`include "soc_config.svh"

module addr_decode (
  input  logic [31:0]      addr_i,
  input  logic             valid_i,
  output bus_pkg::target_e target_o,
  output logic [31:0]      offset_o
);

  always_comb begin
    target_o = bus_pkg::TGT_NONE;
    offset_o = '0;
    if (valid_i) begin
      if (addr_i >= `SOC_CLINT_BASE && addr_i < `SOC_CLINT_TOP) begin
        target_o = bus_pkg::TGT_CLINT;
        offset_o = addr_i - `SOC_CLINT_BASE;
      end else if (addr_i >= `SOC_BRAM_BASE && addr_i < `SOC_BRAM_TOP) begin
        target_o = bus_pkg::TGT_BRAM;
        offset_o = addr_i - `SOC_BRAM_BASE;
      end
      // Unmapped stays TGT_NONE and is never granted.
    end
  end

endmodule

//--- src/clint_pkg.sv
package clint_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // CLINT register map, offsets from the region base.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [15:0] {
    REG_MSIP    = 16'h0000,
    REG_CMP_LO  = 16'h4000,
    REG_CMP_HI  = 16'h4004,
    REG_TIME_LO = 16'hBFF8,
    REG_TIME_HI = 16'hBFFC,
    REG_NONE    = 16'hFFFF   // Anything unmapped.
  } clint_reg_e;

endpackage

//--- src/bus_pkg.sv
package bus_pkg;

  // Region hit by a request.
  typedef enum logic [1:0] {
    TGT_NONE  = 2'd0,
    TGT_BRAM  = 2'd1,
    TGT_CLINT = 2'd2
  } target_e;

  // Which requester currently holds a target.
  typedef enum logic [1:0] {
    OWN_IDLE  = 2'd0,
    OWN_INSTR = 2'd1,
    OWN_DATA  = 2'd2
  } owner_e;

endpackage

//--- src/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map, top addresses exclusive.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SOC_BRAM_BASE  32'h0000_0000
`define SOC_BRAM_TOP   32'h0000_1000

`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_TOP  32'h0200_C000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SOC_BRAM_WORDS 1024
`define SOC_RTC_DIV    8     // clk cycles per mtime step.

`endif
